// ==== common/idu_pkg.sv ====
package idu_pkg;

	// Bus widths
	localparam int BYTE_W    = 8;
	localparam int ADDR_W    = 2 * BYTE_W;  // Pair value and address bus
	localparam int NUM_PAIRS = 5;           // BC, DE, HL, SP, PC

	// IDU step operation
	typedef enum logic [2:0] {
		IDU_PASS     = 3'd0,  // Value goes through unchanged
		IDU_INC16    = 3'd1,  // 16-bit increment, carry into high byte
		IDU_DEC16    = 3'd2,  // 16-bit decrement, borrow into high byte
		IDU_INC_PAIR = 3'd3,  // Both bytes +1, chains split
		IDU_DEC_PAIR = 3'd4   // Both bytes -1, chains split
	} idu_op_t;

	// Register pair select
	typedef enum logic [2:0] {
		PAIR_BC = 3'd0,
		PAIR_DE = 3'd1,
		PAIR_HL = 3'd2,
		PAIR_SP = 3'd3,
		PAIR_PC = 3'd4
		// 5..7 unused
	} pair_sel_t;

	// Increment control, TTB3
	function automatic logic op_is_inc(idu_op_t op);
		return (op == IDU_INC16) || (op == IDU_INC_PAIR);
	endfunction

	// Decrement control, TTB2
	function automatic logic op_is_dec(idu_op_t op);
		return (op == IDU_DEC16) || (op == IDU_DEC_PAIR);
	endfunction

	// Pairwise control, TTB1
	function automatic logic op_is_pairwise(idu_op_t op);
		return (op == IDU_INC_PAIR) || (op == IDU_DEC_PAIR);
	endfunction

endpackage

// ==== idu/inc_dec.sv ====
`timescale 1ns/1ns

module inc_dec (
	input  logic                       clk4,
	input  logic                       reset,
	input  logic                       op_go,     // Step request strobe
	input  idu_pkg::idu_op_t           op_mode,
	input  idu_pkg::pair_sel_t         op_pair,
	input  logic [idu_pkg::BYTE_W-1:0] cbus,      // ~val_lo
	input  logic [idu_pkg::BYTE_W-1:0] dbus,      // ~val_hi
	output logic [idu_pkg::BYTE_W-1:0] res_lo,    // Stepped low byte, true polarity
	output logic [idu_pkg::BYTE_W-1:0] res_hi,
	output logic                       res_valid,
	output idu_pkg::pair_sel_t         res_pair,  // Writeback target
	output logic [idu_pkg::ADDR_W-1:0] cpu_addr,  // Pre-step value
	output logic                       cpu_req
);
	import idu_pkg::*;

	logic [BYTE_W-1:0] cbq;   // Keeper outputs, still inverted
	logic [BYTE_W-1:0] dbq;
	idu_op_t           mode_q;
	pair_sel_t         pair_q;

	logic              step_inc;   // TTB3
	logic              step_dec;   // TTB2
	logic              step_pair;  // TTB1
	logic [ADDR_W-1:0] val;        // True value fed to the cells
	logic [ADDR_W-1:0] res;
	logic [ADDR_W-1:0] mq;         // Per-bit carry out
	logic [ADDR_W-1:0] xa;         // Per-bit carry in
	logic              ct;         // Carry into the high chain

	// Bus keepers, capture the inverted pair on a step request
	always_ff @(posedge clk4) begin
		if (op_go) begin
			cbq <= cbus;
			dbq <= dbus;
		end
	end

	always_ff @(posedge clk4) begin
		if (reset) begin
			res_valid <= 1'b0;
			mode_q    <= IDU_PASS;
			pair_q    <= PAIR_BC;
		end else begin
			res_valid <= op_go;  // Fixed one-cycle latency
			if (op_go) begin
				mode_q <= op_mode;
				pair_q <= op_pair;
			end
		end
	end

	assign step_inc  = op_is_inc(mode_q);
	assign step_dec  = op_is_dec(mode_q);
	assign step_pair = op_is_pairwise(mode_q);

	assign val = ~{dbq, cbq};  // Undo the inverse hold

	// Step cells
	for (genvar i = 0; i < ADDR_W; i++) begin : g_cell
		assign res[i] = val[i] ^ xa[i];
		assign mq[i]  = val[i] ? step_inc : step_dec;  // 1 bit carries on inc, 0 bit on dec
	end

	// Split carry chain
	always_comb begin
		xa[0] = step_inc | step_dec;  // Low chain live on any step
		for (int i = 1; i < BYTE_W; i++) begin
			xa[i] = xa[i-1] & mq[i-1];
		end
		// Pairwise mode forces the high chain on, no byte-to-byte carry
		ct         = (xa[BYTE_W-1] & mq[BYTE_W-1]) | step_pair;
		xa[BYTE_W] = ct;
		for (int i = BYTE_W + 1; i < ADDR_W; i++) begin
			xa[i] = xa[i-1] & mq[i-1];
		end
	end

	assign res_lo   = res[BYTE_W-1:0];
	assign res_hi   = res[ADDR_W-1:BYTE_W];
	assign res_pair = pair_q;

	// Address comes straight off the keepers
	assign cpu_addr = val;
	assign cpu_req  = res_valid;

	// Result appears exactly one cycle after the request
	assert property (@(posedge clk4) disable iff (reset) op_go |=> res_valid)
		else $error("inc_dec: no result one cycle after op_go");

endmodule

// ==== src/reg_pairs.sv ====
`timescale 1ns/1ns

module reg_pairs (
	input  logic                       clk4,
	input  logic                       reset,
	input  logic                       wr_go,      // Load strobe
	input  idu_pkg::pair_sel_t         wr_pair,
	input  logic [idu_pkg::ADDR_W-1:0] wr_data,
	input  idu_pkg::pair_sel_t         op_pair,    // IDU source select
	output logic [idu_pkg::BYTE_W-1:0] cbus,       // ~val_lo
	output logic [idu_pkg::BYTE_W-1:0] dbus,       // ~val_hi
	input  logic                       res_valid,
	input  idu_pkg::pair_sel_t         res_pair,
	input  logic [idu_pkg::BYTE_W-1:0] res_lo,
	input  logic [idu_pkg::BYTE_W-1:0] res_hi,
	input  idu_pkg::pair_sel_t         rd_pair,
	output logic [idu_pkg::ADDR_W-1:0] rd_data     // True value
);
	import idu_pkg::*;

	logic [ADDR_W-1:0] pair_q [NUM_PAIRS];  // Each pair held as ~val
	logic [ADDR_W-1:0] res_n;               // Result after the input inverter
	logic [ADDR_W-1:0] op_q;                // Inverted source for the IDU
	logic              fwd;
	logic              op_ok;
	logic              rd_ok;

	assign res_n = ~{res_hi, res_lo};

	// Writeback beats a load to the same pair
	always_ff @(posedge clk4) begin
		if (reset) begin
			for (int i = 0; i < NUM_PAIRS; i++) begin
				pair_q[i] <= '1;  // Reads back as 0
			end
		end else begin
			for (int i = 0; i < NUM_PAIRS; i++) begin
				if (res_valid && (res_pair == pair_sel_t'(i))) begin
					pair_q[i] <= res_n;
				end else if (wr_go && (wr_pair == pair_sel_t'(i))) begin
					pair_q[i] <= ~wr_data;  // Input inverter
				end
			end
		end
	end

	assign op_ok = int'(op_pair) < NUM_PAIRS;
	assign rd_ok = int'(rd_pair) < NUM_PAIRS;

	// Back-to-back step on the pair being written takes the fresh result
	assign fwd = res_valid && (res_pair == op_pair);

	always_comb begin
		if (fwd) begin
			op_q = res_n;
		end else if (op_ok) begin
			op_q = pair_q[op_pair];
		end else begin
			op_q = '1;  // Unused code, looks like zero
		end
	end

	assign cbus = op_q[BYTE_W-1:0];
	assign dbus = op_q[ADDR_W-1:BYTE_W];

	// Read port, no forwarding
	assign rd_data = rd_ok ? ~pair_q[rd_pair] : '0;

	// Selector that actually writes must name a real pair
	// res_pair arrives from the IDU one cycle after its op_go
	assert property (@(posedge clk4) disable iff (reset)
		(!wr_go || (int'(wr_pair) < NUM_PAIRS)) &&
		(!res_valid || (int'(res_pair) < NUM_PAIRS)))
		else $error("reg_pairs: pair selector out of range on a write");

endmodule

// ==== src/dma_engine.sv ====
`timescale 1ns/1ns

module dma_engine #(
	parameter int DMA_LEN = 160  // Addresses per copy, 1..256
) (
	input  logic                       clk4,
	input  logic                       reset,
	input  logic                       dma_start,      // Start strobe
	input  logic [idu_pkg::BYTE_W-1:0] dma_page,       // Source page, high address byte
	input  logic                       addr_from_dma,  // Granted this cycle
	output logic [idu_pkg::ADDR_W-1:0] dma_addr,
	output logic                       dma_req,
	output logic                       dma_busy
);
	import idu_pkg::*;

	localparam int IDX_W = BYTE_W + 1;  // Holds 256 for the range check

	logic [BYTE_W-1:0] page_q;
	logic [IDX_W-1:0]  idx_q;   // Offset within the page
	logic              busy_q;
	logic              last;
	logic              start;

	assign start = dma_start && !busy_q;  // Retrigger ignored mid-run
	assign last  = idx_q == IDX_W'(DMA_LEN - 1);

	// Page latch
	always_ff @(posedge clk4) begin
		if (start) begin
			page_q <= dma_page;
		end
	end

	always_ff @(posedge clk4) begin
		if (reset) begin
			busy_q <= 1'b0;
			idx_q  <= '0;
		end else if (start) begin
			busy_q <= 1'b1;
			idx_q  <= '0;
		end else if (busy_q && addr_from_dma) begin  // Moves only when on the bus
			if (last) begin
				busy_q <= 1'b0;  // Final address went out
			end else begin
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	assign dma_addr = {page_q, idx_q[BYTE_W-1:0]};
	assign dma_req  = busy_q;
	assign dma_busy = busy_q;

	// Index stays inside the block for the whole run
	assert property (@(posedge clk4) disable iff (reset)
		busy_q |-> (idx_q < IDX_W'(DMA_LEN)))
		else $error("dma_engine: index ran past the block length");

	// Grant from the arbiter only while a run is active
	assert property (@(posedge clk4) disable iff (reset)
		addr_from_dma |-> busy_q)
		else $error("dma_engine: bus granted while idle");

endmodule

// ==== src/addr_arbiter.sv ====
`timescale 1ns/1ns

module addr_arbiter #(
	parameter bit DMA_PRIO = 1'b1  // 1: DMA wins, 0: CPU wins
) (
	input  logic                       clk4,      // Assertion sampling only
	input  logic                       cpu_req,
	input  logic [idu_pkg::ADDR_W-1:0] cpu_addr,
	input  logic                       dma_req,
	input  logic [idu_pkg::ADDR_W-1:0] dma_addr,
	output logic [idu_pkg::ADDR_W-1:0] addr_bus,
	output logic                       addr_valid,
	output logic                       addr_from_dma  // Owner flag, also DMA advance
);

	logic dma_grant;
	logic cpu_disable;  // BUS_DISABLE for the IDU address
	logic cpu_grant;

	// Priority select
	always_comb begin
		if (DMA_PRIO) begin
			dma_grant = dma_req;
		end else begin
			dma_grant = dma_req && !cpu_req;  // DMA waits out the CPU
		end
	end

	assign cpu_disable = dma_grant;
	assign cpu_grant   = cpu_req && !cpu_disable;  // Lost CPU address just drops

	// Bus mux, zero when nobody drives
	always_comb begin
		if (dma_grant) begin
			addr_bus = dma_addr;
		end else if (cpu_grant) begin
			addr_bus = cpu_addr;
		end else begin
			addr_bus = '0;
		end
	end

	assign addr_valid    = dma_grant || cpu_grant;
	assign addr_from_dma = dma_grant;

	// Owner flag only with a live DMA request
	assert property (@(posedge clk4) addr_from_dma |-> dma_req)
		else $error("addr_arbiter: DMA owns the bus without a request");

endmodule

// ==== src/idu_top.sv ====
`timescale 1ns/1ns

module idu_top #(
	parameter int DMA_LEN  = 160,
	parameter bit DMA_PRIO = 1'b1
) (
	input  logic                       clk4,
	input  logic                       reset,
	input  logic                       op_go,
	input  idu_pkg::idu_op_t           op_mode,
	input  idu_pkg::pair_sel_t         op_pair,
	input  logic                       wr_go,
	input  idu_pkg::pair_sel_t         wr_pair,
	input  logic [idu_pkg::ADDR_W-1:0] wr_data,
	input  idu_pkg::pair_sel_t         rd_pair,
	output logic [idu_pkg::ADDR_W-1:0] rd_data,
	input  logic                       dma_start,
	input  logic [idu_pkg::BYTE_W-1:0] dma_page,
	output logic                       dma_busy,
	output logic [idu_pkg::ADDR_W-1:0] addr_bus,
	output logic                       addr_valid,
	output logic                       addr_from_dma
);
	import idu_pkg::*;

	logic [BYTE_W-1:0] cbus;  // Inverted pair bytes into the IDU
	logic [BYTE_W-1:0] dbus;
	logic [BYTE_W-1:0] res_lo;
	logic [BYTE_W-1:0] res_hi;
	logic              res_valid;
	pair_sel_t         res_pair;
	logic [ADDR_W-1:0] cpu_addr;
	logic              cpu_req;
	logic [ADDR_W-1:0] dma_addr;
	logic              dma_req;

	reg_pairs u_reg_pairs (
		.clk4, .reset, .wr_go, .wr_pair, .wr_data, .op_pair, .cbus, .dbus,
		.res_valid, .res_pair, .res_lo, .res_hi, .rd_pair, .rd_data
	);

	inc_dec u_inc_dec (
		.clk4, .reset, .op_go, .op_mode, .op_pair, .cbus, .dbus,
		.res_lo, .res_hi, .res_valid, .res_pair, .cpu_addr, .cpu_req
	);

	dma_engine #(.DMA_LEN(DMA_LEN)) u_dma_engine (
		.clk4, .reset, .dma_start, .dma_page, .addr_from_dma,
		.dma_addr, .dma_req, .dma_busy
	);

	addr_arbiter #(.DMA_PRIO(DMA_PRIO)) u_addr_arbiter (
		.clk4, .cpu_req, .cpu_addr, .dma_req, .dma_addr,
		.addr_bus, .addr_valid, .addr_from_dma
	);

endmodule

// ==== test/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Check tallies, bumped from the action blocks below
int pass_cnt = 0;
int fail_cnt = 0;

task automatic log_pass(input string name);
	pass_cnt++;
	$display("[PASS] %s", name);
endtask

task automatic report_mismatch(input string name, input logic [ADDR_W-1:0] exp,
		input logic [ADDR_W-1:0] act);
	fail_cnt++;
	$display("[FAIL] %s expected %h actual %h", name, exp, act);
endtask

task automatic report_problem(input string name, input string what);
	fail_cnt++;
	$display("%s: %s", name, what);
endtask

// Quiet outputs right after reset
assert property (@(posedge clk4) disable iff (reset)
	chk_idle |-> !dut0.u_inc_dec.res_valid && !dma_busy && !addr_valid && !addr_from_dma) begin
	if ($sampled(chk_idle)) log_pass(test_name);
end else begin
	report_problem(test_name, "res_valid, dma_busy or addr_valid was not low after reset");
end

// Read port against the model
assert property (@(posedge clk4) disable iff (reset) chk_rd |-> rd_data == exp_rd) begin
	if ($sampled(chk_rd)) log_pass(rd_name);
end else begin
	report_mismatch(rd_name, exp_rd, $sampled(rd_data));
end

// Pre-step CPU address one cycle after op_go
assert property (@(posedge clk4) disable iff (reset)
	chk_addr |-> addr_valid && !addr_from_dma && addr_bus == exp_addr) begin
	if ($sampled(chk_addr)) log_pass(test_name);
end else begin
	if (!$sampled(addr_valid) || $sampled(addr_from_dma))
		report_problem(test_name, "the CPU address was not on the bus");
	else
		report_mismatch(test_name, exp_addr, $sampled(addr_bus));
end

// DMA owns the bus, address in sequence
assert property (@(posedge clk4) disable iff (reset)
	chk_dma |-> addr_from_dma && addr_valid && dma_busy && addr_bus == exp_dma) begin
	if ($sampled(chk_dma)) log_pass(test_name);
end else begin
	if (!$sampled(addr_from_dma) || !$sampled(dma_busy))
		report_problem(test_name, "the DMA engine did not own the address bus");
	else
		report_mismatch(test_name, exp_dma, $sampled(addr_bus));
end

// Engine idle before and after a run
assert property (@(posedge clk4) disable iff (reset)
	chk_dma_off |-> !dma_busy && !addr_from_dma) begin
	if ($sampled(chk_dma_off)) log_pass(test_name);
end else begin
	report_problem(test_name, "dma_busy was high outside the block copy");
end

`endif

// ==== test/tb_idu_top.sv ====
`timescale 1ns/1ns

module tb_idu_top;
	import idu_pkg::*;

	localparam int DMA_LEN  = 160;
	localparam bit DMA_PRIO = 1'b1;
	localparam int NUM_OPS  = 39;  // op_go pulses over the whole run
	localparam int WATCHDOG_CYCLES = NUM_OPS + 2 * DMA_LEN + 100;

	logic              clk4 = 1'b0;
	logic              reset;
	logic              op_go;
	idu_op_t           op_mode;
	pair_sel_t         op_pair;
	logic              wr_go;
	pair_sel_t         wr_pair;
	logic [ADDR_W-1:0] wr_data;
	pair_sel_t         rd_pair;
	logic [ADDR_W-1:0] rd_data;
	logic              dma_start;
	logic [BYTE_W-1:0] dma_page;
	logic              dma_busy;
	logic [ADDR_W-1:0] addr_bus;
	logic              addr_valid;
	logic              addr_from_dma;

	logic              chk_idle;     // Check strobes, stable across the sampling edge
	logic              chk_rd;
	logic              chk_addr;
	logic              chk_dma;
	logic              chk_dma_off;
	logic [ADDR_W-1:0] exp_rd;
	logic [ADDR_W-1:0] exp_addr;
	logic [ADDR_W-1:0] exp_dma;
	string             test_name;
	string             rd_name;      // Read check can overlap a DMA check

	logic [ADDR_W-1:0] model [NUM_PAIRS];  // Reference pair values, true polarity
	idu_op_t           burst_ops [8];
	logic [ADDR_W-1:0] vals [6];
	integer            seed;

	`include "tb_checks.svh"

	idu_top #(.DMA_LEN(DMA_LEN), .DMA_PRIO(DMA_PRIO)) dut0 (
		.clk4, .reset, .op_go, .op_mode, .op_pair, .wr_go, .wr_pair, .wr_data,
		.rd_pair, .rd_data, .dma_start, .dma_page, .dma_busy,
		.addr_bus, .addr_valid, .addr_from_dma
	);

	always #4 clk4 = ~clk4;  // 8 ns period

	// Step rules as plain arithmetic
	function automatic logic [ADDR_W-1:0] model_step(logic [ADDR_W-1:0] v, idu_op_t m);
		logic [BYTE_W-1:0] lo;
		logic [BYTE_W-1:0] hi;
		lo = v[BYTE_W-1:0];
		hi = v[ADDR_W-1:BYTE_W];
		case (m)
			IDU_INC16:    return v + 1'b1;   // Wraps mod 2^16
			IDU_DEC16:    return v - 1'b1;
			IDU_INC_PAIR: return {hi + 8'd1, lo + 8'd1};  // Each byte mod 256
			IDU_DEC_PAIR: return {hi - 8'd1, lo - 8'd1};
			default:      return v;
		endcase
	endfunction

	// Edge plus 1 ns, strobes back to idle
	task automatic next_cycle();
		@(posedge clk4);
		#1;
		op_go       = 1'b0;
		wr_go       = 1'b0;
		dma_start   = 1'b0;
		chk_idle    = 1'b0;
		chk_rd      = 1'b0;
		chk_addr    = 1'b0;
		chk_dma     = 1'b0;
		chk_dma_off = 1'b0;
	endtask

	task automatic load_pair(input pair_sel_t p, input logic [ADDR_W-1:0] v);
		next_cycle();
		wr_go   = 1'b1;
		wr_pair = p;
		wr_data = v;
		model[p] = v;
	endtask

	// n ops back to back, address checked the cycle after each op_go
	task automatic run_burst(input pair_sel_t p, input int n);
		logic [ADDR_W-1:0] pre;
		string             name;
		pre  = '0;
		name = $sformatf("%s x%0d on %s", burst_ops[0].name(), n, p.name());
		for (int k = 0; k <= n; k++) begin
			next_cycle();
			test_name = $sformatf("%s addr %0d", name, k - 1);
			if (k > 0) begin
				exp_addr = pre;
				chk_addr = 1'b1;
			end
			if (k < n) begin
				op_go    = 1'b1;
				op_mode  = burst_ops[k];
				op_pair  = p;
				pre      = model[p];
				model[p] = model_step(model[p], burst_ops[k]);
			end
		end
		next_cycle();  // Last writeback landed at the previous edge
		rd_pair = p;
		exp_rd  = model[p];
		rd_name = {name, " result"};
		chk_rd  = 1'b1;
	endtask

	task automatic check_single(input pair_sel_t p, input logic [ADDR_W-1:0] v, input idu_op_t m);
		load_pair(p, v);
		burst_ops[0] = m;
		run_burst(p, 1);
	endtask

	task automatic check_dma();
		logic [BYTE_W-1:0] page;
		page = BYTE_W'($random(seed));
		next_cycle();
		dma_start   = 1'b1;
		dma_page    = page;
		test_name   = "dma idle at start";
		chk_dma_off = 1'b1;
		for (int i = 0; i < DMA_LEN; i++) begin
			next_cycle();
			test_name = $sformatf("dma addr %0d", i);
			exp_dma   = {page, BYTE_W'(i)};
			chk_dma   = 1'b1;
			if (i == 40) begin  // CPU step mid-run, its address loses the bus
				op_go    = 1'b1;
				op_mode  = IDU_INC16;
				op_pair  = PAIR_DE;
				model[PAIR_DE] = model_step(model[PAIR_DE], IDU_INC16);
			end
			if (i == 42) begin
				rd_pair = PAIR_DE;
				exp_rd  = model[PAIR_DE];
				rd_name = "IDU_INC16 during dma result";
				chk_rd  = 1'b1;
			end
		end
		next_cycle();
		test_name   = "dma done after block length";
		chk_dma_off = 1'b1;
	endtask

	initial begin
		seed        = 49863;
		reset       = 1'b1;
		op_go       = 1'b0;
		op_mode     = IDU_PASS;
		op_pair     = PAIR_BC;
		wr_go       = 1'b0;
		wr_pair     = PAIR_BC;
		wr_data     = '0;
		rd_pair     = PAIR_BC;
		dma_start   = 1'b0;
		dma_page    = '0;
		chk_idle    = 1'b0;
		chk_rd      = 1'b0;
		chk_addr    = 1'b0;
		chk_dma     = 1'b0;
		chk_dma_off = 1'b0;
		exp_rd      = '0;
		exp_addr    = '0;
		exp_dma     = '0;
		for (int i = 0; i < NUM_PAIRS; i++) model[i] = '0;
		vals[0] = ADDR_W'($random(seed));
		vals[1] = 16'h00FF;  // Low byte carries into the high byte
		vals[2] = 16'hFF00;
		vals[3] = 16'h0000;
		vals[4] = 16'hFFFF;
		vals[5] = 16'h0100;  // Borrow out of the high byte
		repeat (10) @(posedge clk4);
		#1;
		reset = 1'b0;
		for (int i = 0; i < NUM_PAIRS; i++) begin
			next_cycle();
			rd_pair   = pair_sel_t'(i);
			exp_rd    = '0;
			rd_name   = $sformatf("reset value %s", rd_pair.name());
			test_name = "outputs idle after reset";
			chk_rd    = 1'b1;
			chk_idle  = 1'b1;
		end
		for (int i = 0; i < 6; i++) begin
			check_single(pair_sel_t'(i % NUM_PAIRS), vals[i], IDU_INC16);
			check_single(pair_sel_t'(i % NUM_PAIRS), vals[i], IDU_DEC16);
			check_single(pair_sel_t'(i % NUM_PAIRS), vals[i], IDU_INC_PAIR);
			check_single(pair_sel_t'(i % NUM_PAIRS), vals[i], IDU_DEC_PAIR);
			check_single(pair_sel_t'(i % NUM_PAIRS), vals[i], IDU_PASS);
		end
		burst_ops = '{IDU_INC16, IDU_INC16, IDU_DEC_PAIR, IDU_INC_PAIR,
			IDU_INC16, IDU_DEC16, IDU_INC16, IDU_INC_PAIR};  // Forwarding every cycle
		load_pair(PAIR_HL, 16'h12FE);
		run_burst(PAIR_HL, 8);
		check_dma();
		next_cycle();
		next_cycle();
		$display("checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && pass_cnt > 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk4);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+test
common/idu_pkg.sv
idu/inc_dec.sv
src/reg_pairs.sv
src/dma_engine.sv
src/addr_arbiter.sv
src/idu_top.sv
test/tb_idu_top.sv

// ==== Bender.yml ====
package:
  name: idu_top

sources:
  # Shared package first
  - common/idu_pkg.sv
  # RTL
  - idu/inc_dec.sv
  - src/reg_pairs.sv
  - src/dma_engine.sv
  - src/addr_arbiter.sv
  - src/idu_top.sv
  # Testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_idu_top.sv
